/* hdl/sparc_pkg.sv */
package sparc_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  op3_t;
	// N, Z, V, C from the msb down
	typedef logic [3:0]  icc_t;
	// Encoded as op3[1:0] of the memory instructions
	typedef logic [1:0]  mem_size_t;

	localparam op3_t op3_add  = 6'b000000;
	localparam op3_t op3_and  = 6'b000001;
	localparam op3_t op3_or   = 6'b000010;
	localparam op3_t op3_xor  = 6'b000011;
	localparam op3_t op3_sub  = 6'b000100;
	localparam op3_t op3_andn = 6'b000101;
	localparam op3_t op3_orn  = 6'b000110;
	localparam op3_t op3_xnor = 6'b000111;

	// Memory group, op = 11
	localparam op3_t op3_ld   = 6'b000000;
	localparam op3_t op3_ldub = 6'b000001;
	localparam op3_t op3_lduh = 6'b000010;
	localparam op3_t op3_ldsb = 6'b001001;
	localparam op3_t op3_ldsh = 6'b001010;
	localparam op3_t op3_st   = 6'b000100;
	localparam op3_t op3_stb  = 6'b000101;
	localparam op3_t op3_sth  = 6'b000110;

	localparam mem_size_t size_word = 2'b00;
	localparam mem_size_t size_byte = 2'b01;
	localparam mem_size_t size_half = 2'b10;

	localparam logic rf_wsel_alu = 1'b0;
	localparam logic rf_wsel_mdr = 1'b1;

	typedef enum logic [2:0] {
		alu_add, alu_and, alu_or, alu_xor, alu_sub, alu_andn, alu_orn, alu_xnor
	} alu_fn_e;

	typedef enum logic [1:0] {
		s_idle, s_exec, s_bus, s_writeback
	} ctrl_state_e;

	typedef struct packed {
		logic      ir_load;
		logic      rf_we;
		logic      rf_wsel;
		logic      alub_imm;
		alu_fn_e   alu_fn;
		logic      icc_en;
		logic      mar_en;
		logic      mdr_en;
		mem_size_t mem_size;
		logic      mem_signed;
	} ctrl_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		word_t      adr;
		logic [3:0] sel;
		word_t      dat;
	} wb_req_t;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  sparc_pkg::word_t   a,
	input  sparc_pkg::word_t   b,
	input  sparc_pkg::alu_fn_e fn,
	output sparc_pkg::word_t   y,
	output sparc_pkg::icc_t    icc_next
);
	import sparc_pkg::*;

	logic [32:0] sum;
	logic [32:0] diff;
	logic        v;
	logic        c;

	// Bit 32 is the carry out, or the borrow for sub
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		v = 1'b0;
		c = 1'b0;
		case (fn)
			alu_add: begin
				y = sum[31:0];
				c = sum[32];
				v = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			alu_sub: begin
				y = diff[31:0];
				c = diff[32];
				v = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			alu_and:  y = a & b;
			alu_or:   y = a | b;
			alu_xor:  y = a ^ b;
			alu_andn: y = a & ~b;
			alu_orn:  y = a | ~b;
			alu_xnor: y = ~(a ^ b);
			default:  y = '0;
		endcase
	end

	assign icc_next = {y[31], (y == '0), v, c};

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  sparc_pkg::reg_addr_t  ra,
	input  sparc_pkg::reg_addr_t  rb,
	input  sparc_pkg::reg_addr_t  wa,
	input  sparc_pkg::word_t      wd,
	input  logic                  we,
	output sparc_pkg::word_t      da,
	output sparc_pkg::word_t      db
);
	import sparc_pkg::*;

	// No storage behind r0
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	assign da = (ra == '0) ? '0 : regs[ra];
	assign db = (rb == '0) ? '0 : regs[rb];

endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input  logic             clk,
	input  logic             rst_n,
	input  sparc_pkg::word_t instr,
	input  sparc_pkg::ctrl_t ctrl,
	input  sparc_pkg::word_t wb_dat_rd,
	output sparc_pkg::word_t ir,
	output sparc_pkg::word_t adr,
	output sparc_pkg::word_t dat_wr,
	output logic [3:0]       sel,
	output sparc_pkg::icc_t  icc
);
	import sparc_pkg::*;

	word_t     mar;
	word_t     mdr;
	word_t     rf_a;
	word_t     rf_b;
	word_t     simm;
	word_t     alu_b;
	word_t     alu_y;
	word_t     load_val;
	word_t     wd;
	icc_t      icc_next;
	reg_addr_t rb;
	logic      is_store;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;

	// op3[2] only set on stores within the memory group
	assign is_store = (ir[31:30] == 2'b11) && ir[21];
	// Port b moves from rs2 to rd once the address sits in MAR
	assign rb = (is_store && !ctrl.mar_en) ? ir[29:25] : ir[4:0];

	assign simm  = {{19{ir[12]}}, ir[12:0]};
	assign alu_b = ctrl.alub_imm ? simm : rf_b;
	assign wd    = (ctrl.rf_wsel == rf_wsel_mdr) ? load_val : alu_y;

	register_file register_file_i (
		.clk(clk), .rst_n(rst_n),
		.ra(ir[18:14]), .rb(rb), .wa(ir[29:25]),
		.wd(wd), .we(ctrl.rf_we),
		.da(rf_a), .db(rf_b)
	);

	alu alu_i (.a(rf_a), .b(alu_b), .fn(ctrl.alu_fn), .y(alu_y), .icc_next(icc_next));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ir  <= '0;
			icc <= '0;
		end else begin
			if (ctrl.ir_load) ir <= instr;
			if (ctrl.icc_en) icc <= icc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.mar_en) mar <= alu_y;
		if (ctrl.mdr_en) mdr <= wb_dat_rd;
	end

	assign adr = mar;

	// Big-endian lanes, offset 0 lives in bits 31:24
	always_comb begin
		ld_byte = mdr[31 - 8 * mar[1:0] -: 8];
		ld_half = mar[1] ? mdr[15:0] : mdr[31:16];
		case (ctrl.mem_size)
			size_byte: load_val = {{24{ctrl.mem_signed & ld_byte[7]}}, ld_byte};
			size_half: load_val = {{16{ctrl.mem_signed & ld_half[15]}}, ld_half};
			default:   load_val = mdr;
		endcase
	end

	always_comb begin
		case (ctrl.mem_size)
			size_byte: begin
				dat_wr = {4{rf_b[7:0]}};
				sel    = 4'b1000 >> mar[1:0];
			end
			size_half: begin
				dat_wr = {2{rf_b[15:0]}};
				sel    = mar[1] ? 4'b0011 : 4'b1100;
			end
			default: begin
				dat_wr = rf_b;
				sel    = 4'b1111;
			end
		endcase
	end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
	input  logic             clk,
	input  logic             rst_n,
	input  sparc_pkg::word_t ir,
	input  logic             instr_valid,
	output logic             instr_ready,
	input  logic             wb_ack,
	output logic             cyc,
	output logic             stb,
	output logic             we,
	output sparc_pkg::ctrl_t ctrl
);
	import sparc_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic [1:0]  op;
	op3_t        op3;
	logic        is_alu;
	logic        is_load;
	logic        is_store;
	logic        is_mem;

	assign op  = ir[31:30];
	assign op3 = ir[24:19];

	// Logic and add/sub group, op3[4] picks the cc form
	assign is_alu = (op == 2'b10) && !op3[5] && !op3[3];

	always_comb begin
		is_load  = 1'b0;
		is_store = 1'b0;
		if (op == 2'b11) begin
			case (op3)
				op3_ld, op3_ldub, op3_lduh, op3_ldsb, op3_ldsh: begin
					is_load = 1'b1;
				end
				op3_st, op3_stb, op3_sth: begin
					is_store = 1'b1;
				end
				default: begin
					is_load  = 1'b0;
					is_store = 1'b0;
				end
			endcase
		end
	end

	assign is_mem = is_load || is_store;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		ctrl       = '0;

		// Operand and size selects follow the IR, enables follow the state
		ctrl.alub_imm   = ir[13];
		ctrl.alu_fn     = is_alu ? alu_fn_e'(op3[2:0]) : alu_add;
		ctrl.mem_size   = op3[1:0];
		ctrl.mem_signed = op3[3];

		case (state)
			s_idle: begin
				ctrl.ir_load = instr_valid;
				if (instr_valid) begin
					state_next = s_exec;
				end
			end
			s_exec: begin
				// Unsupported codes fall through here with nothing enabled
				ctrl.rf_we  = is_alu;
				ctrl.icc_en = is_alu && op3[4];
				ctrl.mar_en = is_mem;
				state_next  = is_mem ? s_bus : s_idle;
			end
			s_bus: begin
				ctrl.mdr_en = is_load && wb_ack;
				if (wb_ack) begin
					state_next = is_load ? s_writeback : s_idle;
				end
			end
			s_writeback: begin
				ctrl.rf_we   = 1'b1;
				ctrl.rf_wsel = rf_wsel_mdr;
				state_next   = s_idle;
			end
			default: begin
				state_next = s_idle;
			end
		endcase
	end

	assign instr_ready = (state == s_idle);

	// One classic cycle per memory instruction
	assign cyc = (state == s_bus);
	assign stb = (state == s_bus);
	assign we  = (state == s_bus) && is_store;

endmodule

/* hdl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
	input  logic               clk,
	input  logic               rst_n,
	input  sparc_pkg::word_t   instr,
	input  logic               instr_valid,
	output logic               instr_ready,
	output sparc_pkg::wb_req_t wb_req,
	input  sparc_pkg::word_t   wb_dat_rd,
	input  logic               wb_ack,
	output sparc_pkg::icc_t    icc
);
	import sparc_pkg::*;

	word_t      ir;
	ctrl_t      ctrl;
	logic       cyc;
	logic       stb;
	logic       we;
	word_t      adr;
	word_t      dat_wr;
	logic [3:0] sel;

	control_unit control_unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.ir(ir),
		.instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.wb_ack(wb_ack),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.ctrl(ctrl)
	);

	datapath datapath_i (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.ctrl(ctrl),
		.wb_dat_rd(wb_dat_rd),
		.ir(ir),
		.adr(adr),
		.dat_wr(dat_wr),
		.sel(sel),
		.icc(icc)
	);

	// Strobes from the FSM, address and data from the datapath
	assign wb_req.cyc = cyc;
	assign wb_req.stb = stb;
	assign wb_req.we  = we;
	assign wb_req.adr = adr;
	assign wb_req.sel = sel;
	assign wb_req.dat = dat_wr;

endmodule

/* bench/cpu_core_assert.sv */
`timescale 1ns/1ps

module cpu_core_sva (
	input logic               clk,
	input logic               rst_n,
	input logic               instr_ready,
	input sparc_pkg::wb_req_t wb_req,
	input logic               wb_ack
);

	int fail_count = 0;

	// A strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_req.stb |-> wb_req.cyc)
		else begin
			$error("wb stb high without cyc");
			fail_count++;
		end

	// Request held until ack
	req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_req.stb && !wb_ack) |=>
		(wb_req.stb && $stable({wb_req.we, wb_req.adr, wb_req.sel, wb_req.dat})))
		else begin
			$error("wb request changed before ack");
			fail_count++;
		end

	ready_not_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(instr_ready) |-> !wb_req.cyc)
		else begin
			$error("instr_ready rose during a bus cycle");
			fail_count++;
		end

endmodule

bind cpu_core cpu_core_sva sva_i (
	.clk(clk),
	.rst_n(rst_n),
	.instr_ready(instr_ready),
	.wb_req(wb_req),
	.wb_ack(wb_ack)
);

/* bench/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core;
	import sparc_pkg::*;

	localparam int   timeout_cycles = 40;
	localparam op3_t op3_cc         = 6'b010000;

	logic        clk;
	logic        rst_n;
	word_t       instr;
	logic        instr_valid;
	logic        instr_ready;
	wb_req_t     wb_req;
	word_t       wb_dat_rd;
	logic        wb_ack;
	icc_t        icc;

	word_t       mem [0:255];
	word_t       smem [0:255];
	word_t       sreg [0:31];
	icc_t        sicc;
	op3_t        mem_codes [0:7];
	logic [31:0] rng;
	int          ack_delay;
	int          ack_waited;
	logic        cmp_req;
	logic        cmp_store;
	int          cmp_idx;
	logic        hung;
	int          scratch;
	int          checks;
	int          errors;
	int          test_errors;
	int          tests_passed;
	int          tests_failed;

	cpu_core dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.wb_req(wb_req),
		.wb_dat_rd(wb_dat_rd),
		.wb_ack(wb_ack),
		.icc(icc)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	function automatic word_t enc_r(input logic [1:0] op, input op3_t op3, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2);
		return {op, rd, op3, rs1, 1'b0, 8'h00, rs2};
	endfunction

	function automatic word_t enc_i(input logic [1:0] op, input op3_t op3, input reg_addr_t rd,
			input reg_addr_t rs1, input logic [12:0] simm);
		return {op, rd, op3, rs1, 1'b1, simm};
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: time %0t, %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// SPARC V8 semantics on the shadow state
	function automatic void ref_execute(input word_t ins);
		logic [1:0]  op;
		op3_t        op3;
		reg_addr_t   rd;
		word_t       a;
		word_t       b;
		word_t       res;
		word_t       addr;
		logic        v;
		logic        c;
		logic [7:0]  bval;
		logic [15:0] hval;
		int          idx;
		int          lane;

		op  = ins[31:30];
		op3 = ins[24:19];
		rd  = ins[29:25];
		a   = sreg[ins[18:14]];
		b   = ins[13] ? {{19{ins[12]}}, ins[12:0]} : sreg[ins[4:0]];
		res = '0;
		v   = 1'b0;
		c   = 1'b0;
		cmp_store = 1'b0;
		if (op == 2'b10 && !op3[5] && !op3[3]) begin
			case (op3[2:0])
				3'd0: begin
					{c, res} = {1'b0, a} + {1'b0, b};
					v = (a[31] & b[31] & ~res[31]) | (~a[31] & ~b[31] & res[31]);
				end
				3'd4: begin
					res = a - b;
					// Borrow out of the msb
					c = (a < b);
					v = (a[31] & ~b[31] & ~res[31]) | (~a[31] & b[31] & res[31]);
				end
				3'd1: res = a & b;
				3'd2: res = a | b;
				3'd3: res = a ^ b;
				3'd5: res = a & ~b;
				3'd6: res = a | ~b;
				default: res = ~(a ^ b);
			endcase
			if (rd != 0) begin
				sreg[rd] = res;
			end
			if (op3[4]) begin
				sicc = {res[31], (res == 0), v, c};
			end
		end else if (op == 2'b11) begin
			addr = a + b;
			idx  = addr[9:2];
			// Offset 0 is the most significant byte
			lane = 31 - 8 * int'(addr[1:0]);
			bval = smem[idx][lane -: 8];
			hval = addr[1] ? smem[idx][15:0] : smem[idx][31:16];
			case (op3)
				op3_ld:   res = smem[idx];
				op3_ldub: res = {24'b0, bval};
				op3_lduh: res = {16'b0, hval};
				op3_ldsb: res = {{24{bval[7]}}, bval};
				op3_ldsh: res = {{16{hval[15]}}, hval};
				op3_st:   smem[idx] = sreg[rd];
				op3_stb:  smem[idx][lane -: 8] = sreg[rd][7:0];
				op3_sth: begin
					if (addr[1]) begin
						smem[idx][15:0] = sreg[rd][15:0];
					end else begin
						smem[idx][31:16] = sreg[rd][15:0];
					end
				end
				default: res = '0;
			endcase
			if (op3 inside {op3_ld, op3_ldub, op3_lduh, op3_ldsb, op3_ldsh} && rd != 0) begin
				sreg[rd] = res;
			end
			if (op3 inside {op3_st, op3_stb, op3_sth}) begin
				cmp_store = 1'b1;
				cmp_idx   = idx;
			end
		end
	endfunction

	// Word memory answering one classic cycle at a time
	always @(negedge clk) begin
		wb_ack <= 1'b0;
		if (rst_n && wb_req.cyc && wb_req.stb && !wb_ack) begin
			if (ack_waited >= ack_delay) begin
				if (wb_req.we) begin
					for (int i = 0; i < 4; i++) begin
						if (wb_req.sel[i]) begin
							mem[wb_req.adr[9:2]][8 * i +: 8] = wb_req.dat[8 * i +: 8];
						end
					end
				end
				wb_dat_rd  <= mem[wb_req.adr[9:2]];
				wb_ack     <= 1'b1;
				ack_waited = 0;
				ack_delay  = int'(next_rand() >> 30);
			end else begin
				ack_waited++;
			end
		end
	end

	// Checks icc and the touched word after each retired instruction
	always @(negedge clk) begin
		if (cmp_req) begin
			check_value("icc", 32'(icc), 32'(sicc));
			if (cmp_store) begin
				check_value($sformatf("mem[%0d]", cmp_idx), mem[cmp_idx], smem[cmp_idx]);
			end
			cmp_req = 1'b0;
		end
	end

	task automatic issue(input word_t ins);
		int t;

		if (hung) begin
			return;
		end
		ref_execute(ins);
		instr       = ins;
		instr_valid = 1'b1;
		@(negedge clk);
		instr_valid = 1'b0;
		check_value("instr_ready", 32'(instr_ready), 32'd0);
		t = 0;
		while (!instr_ready && t < timeout_cycles) begin
			@(negedge clk);
			t++;
		end
		if (!instr_ready) begin
			$display("instruction %h did not complete within %0d cycles", ins, timeout_cycles);
			errors++;
			hung = 1'b1;
			return;
		end
		cmp_req = 1'b1;
		t = 0;
		while (cmp_req && t < timeout_cycles) begin
			@(negedge clk);
			t++;
		end
		if (cmp_req) begin
			$display("result comparison for %h never ran", ins);
			errors++;
			hung = 1'b1;
		end
	endtask

	// Word store into a rotating scratch area at byte 0x300
	task automatic store_reg(input reg_addr_t r);
		issue(enc_i(2'b11, op3_st, r, 5'd0, 13'(12'h300 + 4 * scratch)));
		scratch = (scratch + 1) % 64;
	endtask

	task automatic start_test();
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errors) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - test_errors);
		end
	endtask

	initial begin
		word_t       ins;
		logic [31:0] pick;
		int          asserts_failed;

		rng = 32'h9790_e46b;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		wb_ack = 1'b0;
		wb_dat_rd = '0;
		ack_delay = 0;
		ack_waited = 0;
		cmp_req = 1'b0;
		cmp_store = 1'b0;
		cmp_idx = 0;
		hung = 1'b0;
		scratch = 0;
		checks = 0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		sicc = '0;
		mem_codes = '{op3_ld, op3_ldub, op3_lduh, op3_ldsb, op3_ldsh, op3_st, op3_stb, op3_sth};
		for (int i = 0; i < 256; i++) begin
			mem[i]  = {8'(i), 8'(~i), 8'(i ^ 8'h96), 8'(i + 8'h80)};
			smem[i] = mem[i];
		end
		for (int i = 0; i < 32; i++) begin
			sreg[i] = '0;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		start_test();
		check_value("instr_ready", 32'(instr_ready), 32'd1);
		check_value("wb_req.cyc", 32'(wb_req.cyc), 32'd0);
		check_value("wb_req.stb", 32'(wb_req.stb), 32'd0);
		check_value("icc", 32'(icc), 32'd0);
		finish_test("reset");

		start_test();
		issue(enc_i(2'b10, op3_or, 5'd1, 5'd0, 13'h05a5));
		issue(enc_i(2'b10, op3_add, 5'd2, 5'd0, 13'h1fff));
		issue(enc_i(2'b10, op3_add, 5'd3, 5'd1, 13'h1800));
		issue(enc_r(2'b10, op3_xor, 5'd4, 5'd1, 5'd2));
		issue(enc_r(2'b10, op3_andn, 5'd5, 5'd2, 5'd1));
		issue(enc_i(2'b10, op3_orn, 5'd6, 5'd1, 13'h0f0f));
		issue(enc_r(2'b10, op3_xnor, 5'd7, 5'd3, 5'd1));
		issue(enc_r(2'b10, op3_sub, 5'd8, 5'd1, 5'd3));
		issue(enc_i(2'b10, op3_and, 5'd9, 5'd2, 13'h0abc));
		// Result to r0 must be dropped
		issue(enc_r(2'b10, op3_add, 5'd0, 5'd1, 5'd2));
		for (int r = 0; r < 10; r++) begin
			store_reg(5'(r));
		end
		finish_test("alu results");

		start_test();
		issue(enc_i(2'b10, op3_add, 5'd10, 5'd0, 13'h0001));
		for (int k = 0; k < 31; k++) begin
			issue(enc_r(2'b10, op3_add, 5'd10, 5'd10, 5'd10));
		end
		issue(enc_i(2'b10, op3_add, 5'd11, 5'd10, 13'h1fff));
		issue(enc_r(2'b10, op3_add | op3_cc, 5'd12, 5'd10, 5'd10));
		issue(enc_i(2'b10, op3_add | op3_cc, 5'd12, 5'd11, 13'h0001));
		issue(enc_i(2'b10, op3_sub | op3_cc, 5'd12, 5'd0, 13'h0001));
		issue(enc_i(2'b10, op3_sub | op3_cc, 5'd13, 5'd10, 13'h0001));
		issue(enc_r(2'b10, op3_and | op3_cc, 5'd14, 5'd2, 5'd2));
		issue(enc_r(2'b10, op3_xor | op3_cc, 5'd15, 5'd1, 5'd1));
		// Plain add keeps the flags of the xorcc
		issue(enc_r(2'b10, op3_add, 5'd16, 5'd10, 5'd10));
		issue(enc_r(2'b10, op3_orn | op3_cc, 5'd17, 5'd0, 5'd2));
		issue(enc_r(2'b10, op3_xnor | op3_cc, 5'd18, 5'd1, 5'd2));
		for (int r = 10; r < 19; r++) begin
			store_reg(5'(r));
		end
		finish_test("condition codes");

		start_test();
		for (int w = 0; w < 2; w++) begin
			for (int off = 0; off < 4; off++) begin
				ins = enc_i(2'b11, op3_ldub, 5'd20, 5'd0, 13'((w ? 'h244 : 'h080) + off));
				issue(ins);
				store_reg(5'd20);
				ins[24:19] = op3_ldsb;
				issue(ins);
				store_reg(5'd20);
				if (off % 2 == 0) begin
					ins[24:19] = op3_lduh;
					issue(ins);
					store_reg(5'd20);
					ins[24:19] = op3_ldsh;
					issue(ins);
					store_reg(5'd20);
				end
			end
			issue(enc_i(2'b11, op3_ld, 5'd21, 5'd0, w ? 13'h244 : 13'h080));
			store_reg(5'd21);
		end
		finish_test("loads");

		start_test();
		for (int off = 0; off < 4; off++) begin
			issue(enc_i(2'b11, op3_stb, (off % 2) ? 5'd4 : 5'd1, 5'd0, 13'(12'h140 + off)));
		end
		issue(enc_i(2'b11, op3_sth, 5'd1, 5'd0, 13'h0148));
		issue(enc_i(2'b11, op3_sth, 5'd8, 5'd0, 13'h014e));
		finish_test("partial stores");

		start_test();
		for (int n = 0; n < 200; n++) begin
			ins  = next_rand();
			pick = next_rand();
			if (ins[31:30] == 2'b11) begin
				ins[24:19] = mem_codes[pick[2:0]];
			end else if (ins[31:30] == 2'b10 && pick[3]) begin
				// Bias toward the supported ALU codes
				ins[24] = 1'b0;
				ins[22] = 1'b0;
			end
			issue(ins);
		end
		for (int i = 0; i < 256; i++) begin
			check_value($sformatf("mem[%0d]", i), mem[i], smem[i]);
		end
		finish_test("random mix");

		asserts_failed = dut_i.sva_i.fail_count;
		if (asserts_failed != 0) begin
			$display("%0d bus protocol assertions failed", asserts_failed);
			errors += asserts_failed;
		end
		$display("%0d tests passed, %0d tests failed, %0d checks, %0d errors",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* project.f */
hdl/sparc_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/datapath.sv
hdl/control_unit.sv
hdl/cpu_core.sv
bench/cpu_core_assert.sv
bench/tb_cpu_core.sv

/* Bender.yml */
package:
  name: sparc_core

sources:
  - hdl/sparc_pkg.sv
  - hdl/alu.sv
  - hdl/register_file.sv
  - hdl/datapath.sv
  - hdl/control_unit.sv
  - hdl/cpu_core.sv
  - target: test
    files:
      - bench/cpu_core_assert.sv
      - bench/tb_cpu_core.sv
